// ==== routeGen.f ====
routeGenPkg.sv
routePlanner.sv
wordFifo.sv
wordSender.sv
routeGen.sv
routeGenTb.sv

// ==== routeGen.sv ====
// Top level of the routing word generator
// Planner feeds the word buffer, sender drains it to the data port
`timescale 1ns/1ps

module routeGen #(
	parameter int dataWidth  = routeGenPkg::defaultDataWidth,
	parameter int coordWidth = routeGenPkg::defaultCoordWidth,
	parameter int fifoDepth  = 4
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  logic [dataWidth-1:0] myId,
	input  logic [dataWidth-1:0] dstId,
	input  logic [dataWidth-1:0] attribWord,
	input  logic [dataWidth-1:0] rConfig,
	input  logic [dataWidth-1:0] length,
	input  logic [dataWidth-1:0] stride,
	input  logic [dataWidth-1:0] base,
	input  logic                 stall,
	output logic [dataWidth-1:0] data,
	output logic                 dataValid,
	output logic                 busy,
	output logic                 done
);

	// Planner to buffer
	logic                 writeEnable;
	logic [dataWidth-1:0] writeData;
	logic                 writeLast;
	logic                 full;

	// Buffer to sender
	logic [dataWidth-1:0] readData;
	logic                 readLast;
	logic                 empty;
	logic                 readEnable;

	routePlanner #(
		.dataWidth  (dataWidth),
		.coordWidth (coordWidth)
	) planner0 (
		.clock       (clock),
		.reset       (reset),
		.start       (start),
		.myId        (myId),
		.dstId       (dstId),
		.attribWord  (attribWord),
		.rConfig     (rConfig),
		.length      (length),
		.stride      (stride),
		.base        (base),
		.full        (full),
		.done        (done),
		.writeEnable (writeEnable),
		.writeData   (writeData),
		.writeLast   (writeLast),
		.busy        (busy)
	);

	wordFifo #(
		.dataWidth (dataWidth),
		.fifoDepth (fifoDepth)
	) fifo0 (
		.clock       (clock),
		.reset       (reset),
		.writeEnable (writeEnable),
		.writeData   (writeData),
		.writeLast   (writeLast),
		.readEnable  (readEnable),
		.full        (full),
		.empty       (empty),
		.readData    (readData),
		.readLast    (readLast)
	);

	wordSender #(
		.dataWidth (dataWidth)
	) sender0 (
		.clock      (clock),
		.reset      (reset),
		.stall      (stall),
		.readData   (readData),
		.readLast   (readLast),
		.empty      (empty),
		.readEnable (readEnable),
		.data       (data),
		.dataValid  (dataValid),
		.done       (done)
	);

endmodule

// ==== routeGenPkg.sv ====
// Shared types and constants for the mesh routing word generator
// Planner states, direction codes, attribute marker and default widths

package routeGenPkg;

	//////////////////////////////////////////////////////////////
	// Planner FSM
	//////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		idle        = 3'd0,
		sendAttribX = 3'd1,
		sendRouteX  = 3'd2,
		sendAttribY = 3'd3,
		sendRouteY  = 3'd4,
		sendConfig  = 3'd5
	} plannerState;

	//////////////////////////////////////////////////////////////
	// Mesh directions, one-hot
	//////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		north = 4'h1,
		east  = 4'h2,
		west  = 4'h4,
		south = 4'h8
	} directionCode;

	// Kind code in the top nibble of every attribute word
	localparam logic [3:0] attribMarker = 4'h3;

	// Attribute, R-config, length, stride, base
	localparam int configWordCount = 5;

	// Word and coordinate widths
	localparam int defaultDataWidth  = 32;
	localparam int defaultCoordWidth = 8;

endpackage

// ==== routeGenTb.sv ====
// Testbench for the routing word generator
// Word model, stall driver, output monitor, directed and random tests
`timescale 1ns/1ps

module routeGenTb;

	localparam int dataWidth   = routeGenPkg::defaultDataWidth;
	localparam int coordWidth  = routeGenPkg::defaultCoordWidth;
	localparam int seed        = 32'h60b2_92b7;
	localparam int doneTimeout = 300;
	localparam int randomRuns  = 40;

	logic                 clock;
	logic                 reset;
	logic                 start;
	logic [dataWidth-1:0] myId;
	logic [dataWidth-1:0] dstId;
	logic [dataWidth-1:0] attribWord;
	logic [dataWidth-1:0] rConfig;
	logic [dataWidth-1:0] length;
	logic [dataWidth-1:0] stride;
	logic [dataWidth-1:0] base;
	logic                 stall;
	logic [dataWidth-1:0] data;
	logic                 dataValid;
	logic                 busy;
	logic                 done;

	// Expected words, in order, with their last-word flags
	logic [dataWidth-1:0] expWords [$];
	bit                   expLast [$];
	logic [dataWidth-1:0] expWord;
	bit                   expIsLast;
	logic [dataWidth-1:0] heldData;
	bit                   holdPending;
	bit                   activeMessage;
	bit                   stallMode;
	bit                   timedOut;
	int                   errors;
	int                   doneCount;
	string                testName;

	routeGen dut0 (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.myId       (myId),
		.dstId      (dstId),
		.attribWord (attribWord),
		.rConfig    (rConfig),
		.length     (length),
		.stride     (stride),
		.base       (base),
		.stall      (stall),
		.data       (data),
		.dataValid  (dataValid),
		.busy       (busy),
		.done       (done)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	// Receiver stall, mostly high in stall mode so the buffer fills
	initial begin
		stall = 1'b0;
		forever begin
			@(posedge clock);
			#2;
			stall = stallMode && ($urandom_range(0, 2) != 0);
		end
	end

	task automatic reportMismatch(input string what, input logic [dataWidth-1:0] expected,
		input logic [dataWidth-1:0] actual);
		errors++;
		$display("Error %s %s expected %h actual %h", testName, what, expected, actual);
	endtask

	//////////////////////////////////////////////////////////////
	// Reference word model
	//////////////////////////////////////////////////////////////
	task automatic queueAxis(input logic [coordWidth-1:0] fromCoord,
		input logic [coordWidth-1:0] toCoord, input logic [3:0] lowerCode,
		input logic [3:0] higherCode);
		logic [coordWidth-1:0] distance;
		logic [dataWidth-1:0]  word;
		if (fromCoord == toCoord) begin
			return;
		end
		distance = (toCoord > fromCoord) ? toCoord - fromCoord : fromCoord - toCoord;
		word = '0;
		word[dataWidth-1 -: 4] = 4'h3;
		word[8 +: coordWidth] = distance - 1'b1;
		expWords.push_back(word);
		expLast.push_back(1'b0);
		word = '0;
		word[3:0] = (toCoord < fromCoord) ? lowerCode : higherCode;
		expWords.push_back(word);
		expLast.push_back(1'b0);
	endtask

	task automatic runMessage(input logic [coordWidth-1:0] myX, input logic [coordWidth-1:0] myY,
		input logic [coordWidth-1:0] dstX, input logic [coordWidth-1:0] dstY,
		input bit busyStart);
		logic [dataWidth-1:0] cfg [5];
		int waitCount;
		int donesBefore;
		if (timedOut) begin
			return;
		end
		for (int k = 0; k < 5; k++) begin
			cfg[k] = $urandom;
		end
		// X first: west or east, then Y: north or south
		queueAxis(myX, dstX, 4'h4, 4'h2);
		queueAxis(myY, dstY, 4'h1, 4'h8);
		for (int k = 0; k < 5; k++) begin
			expWords.push_back(cfg[k]);
			expLast.push_back(k == 4);
		end
		donesBefore = doneCount;
		myId       = dataWidth'({myY, myX});
		dstId      = dataWidth'({dstY, dstX});
		attribWord = cfg[0];
		rConfig    = cfg[1];
		length     = cfg[2];
		stride     = cfg[3];
		base       = cfg[4];
		start      = 1'b1;
		@(posedge clock);
		#2;
		start = 1'b0;
		assert (busy) else reportMismatch("busyAfterStart", 1, busy);
		activeMessage = 1'b1;
		if (busyStart) begin
			// Second request with swapped IDs must be ignored
			@(posedge clock);
			#2;
			assert (busy) else reportMismatch("busyBeforeSecondStart", 1, busy);
			myId  = dataWidth'({dstY, dstX});
			dstId = dataWidth'({myY, myX});
			base  = ~cfg[4];
			start = 1'b1;
			@(posedge clock);
			#2;
			start = 1'b0;
		end
		waitCount = 0;
		while (doneCount == donesBefore && waitCount < doneTimeout) begin
			@(posedge clock);
			#2;
			waitCount++;
		end
		if (doneCount == donesBefore) begin
			errors++;
			timedOut = 1'b1;
			$display("Timeout in %s: done never arrived for the message", testName);
			return;
		end
		assert (!busy) else reportMismatch("busyAfterDone", 0, busy);
		assert (expWords.size() == 0) else reportMismatch("wordsLeft", 0, expWords.size());
	endtask

	//////////////////////////////////////////////////////////////
	// Output monitor, sampled mid-cycle
	//////////////////////////////////////////////////////////////
	always @(negedge clock) begin
		if (reset) begin
			holdPending = 1'b0;
		end else begin
			if (holdPending) begin
				assert (dataValid && data == heldData) else reportMismatch("stallHold", heldData, data);
			end
			holdPending = dataValid && stall;
			heldData    = data;
			if (dataValid && !stall) begin
				if (expWords.size() == 0) begin
					errors++;
					$display("Word %h accepted in %s while none was expected", data, testName);
				end else begin
					expWord   = expWords.pop_front();
					expIsLast = expLast.pop_front();
					assert (data == expWord) else reportMismatch("word", expWord, data);
					assert (done == expIsLast) else reportMismatch("doneOnWord", expIsLast, done);
				end
			end else begin
				assert (!done) else reportMismatch("doneWithoutWord", 0, done);
			end
			if (activeMessage) begin
				assert (busy) else reportMismatch("busyDuringMessage", 1, busy);
			end
			if (done) begin
				doneCount++;
				activeMessage = 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////
	initial begin
		void'($urandom(seed));
		reset         = 1'b1;
		start         = 1'b0;
		myId          = '0;
		dstId         = '0;
		attribWord    = '0;
		rConfig       = '0;
		length        = '0;
		stride        = '0;
		base          = '0;
		stallMode     = 1'b0;
		timedOut      = 1'b0;
		activeMessage = 1'b0;
		errors        = 0;
		doneCount     = 0;
		testName      = "reset";
		repeat (10) @(posedge clock);
		#2;
		assert (!dataValid && !busy && !done)
			else reportMismatch("outputsInReset", 0, {dataValid, busy, done});
		reset = 1'b0;

		testName = "bothAxes";
		runMessage(8'd1, 8'd1, 8'd4, 8'd6, 1'b0);
		runMessage(8'd5, 8'd7, 8'd2, 8'd3, 1'b0);
		runMessage(8'd2, 8'd9, 8'd7, 8'd0, 1'b0);
		runMessage(8'd0, 8'd255, 8'd255, 8'd0, 1'b0);

		testName = "zeroAxis";
		runMessage(8'd3, 8'd3, 8'd3, 8'd9, 1'b0);
		runMessage(8'd3, 8'd3, 8'd8, 8'd3, 1'b0);
		runMessage(8'd4, 8'd4, 8'd4, 8'd4, 1'b0);

		testName  = "randomStall";
		stallMode = 1'b1;
		runMessage(8'd1, 8'd1, 8'd4, 8'd6, 1'b0);
		runMessage(8'd6, 8'd2, 8'd0, 8'd9, 1'b0);
		runMessage(8'd4, 8'd4, 8'd4, 8'd4, 1'b0);

		testName = "startWhileBusy";
		runMessage(8'd2, 8'd2, 8'd6, 8'd5, 1'b1);
		stallMode = 1'b0;
		runMessage(8'd7, 8'd1, 8'd1, 8'd7, 1'b1);

		testName  = "randomRequests";
		stallMode = 1'b1;
		for (int i = 0; i < randomRuns; i++) begin
			runMessage(coordWidth'($urandom_range(0, 15)), coordWidth'($urandom_range(0, 15)),
				coordWidth'($urandom_range(0, 15)), coordWidth'($urandom_range(0, 15)), i % 5 == 0);
		end
		stallMode = 1'b0;

		// Quiet period, no stray words may appear
		repeat (20) @(posedge clock);
		assert (expWords.size() == 0) else reportMismatch("finalQueue", 0, expWords.size());
		$display("Checks complete with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== routePlanner.sv ====
// Route planner: request capture, per-axis distance and direction,
// and the FSM that writes routing and configuration words to the buffer
`timescale 1ns/1ps

module routePlanner #(
	parameter int dataWidth  = routeGenPkg::defaultDataWidth,
	parameter int coordWidth = routeGenPkg::defaultCoordWidth
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  logic [dataWidth-1:0] myId,
	input  logic [dataWidth-1:0] dstId,
	input  logic [dataWidth-1:0] attribWord,
	input  logic [dataWidth-1:0] rConfig,
	input  logic [dataWidth-1:0] length,
	input  logic [dataWidth-1:0] stride,
	input  logic [dataWidth-1:0] base,
	input  logic                 full,
	input  logic                 done,
	output logic                 writeEnable,
	output logic [dataWidth-1:0] writeData,
	output logic                 writeLast,
	output logic                 busy
);

	localparam int countWidth = $clog2(routeGenPkg::configWordCount);
	localparam logic [countWidth-1:0] lastConfig =
		countWidth'(routeGenPkg::configWordCount - 1);

	routeGenPkg::plannerState state;

	// New request, only taken while not busy
	logic accept;

	// Signed difference per axis, top bit set when dst is below my
	logic [coordWidth:0]   diffX;
	logic [coordWidth:0]   diffY;
	logic [coordWidth-1:0] absX;
	logic [coordWidth-1:0] absY;

	// Captured request
	logic [coordWidth-1:0]     distX;
	logic [coordWidth-1:0]     distY;
	routeGenPkg::directionCode dirX;
	routeGenPkg::directionCode dirY;
	logic                      zeroY;
	logic [dataWidth-1:0]      cfgAttrib;
	logic [dataWidth-1:0]      cfgRConfig;
	logic [dataWidth-1:0]      cfgLength;
	logic [dataWidth-1:0]      cfgStride;
	logic [dataWidth-1:0]      cfgBase;

	logic [countWidth-1:0] configCount;

	// Word composition
	logic [dataWidth-1:0] attribData;
	logic [dataWidth-1:0] routeData;
	logic [dataWidth-1:0] configData;

	function automatic logic [coordWidth-1:0] magnitude(input logic [coordWidth:0] diff);
		if (diff[coordWidth]) begin
			return ~diff[coordWidth-1:0] + 1'b1;
		end
		return diff[coordWidth-1:0];
	endfunction

	//////////////////////////////////////////////////////////////
	// Distance and direction
	//////////////////////////////////////////////////////////////
	assign accept = start && !busy;

	assign diffX = {1'b0, dstId[coordWidth-1:0]} - {1'b0, myId[coordWidth-1:0]};
	assign diffY = {1'b0, dstId[2*coordWidth-1:coordWidth]}
		- {1'b0, myId[2*coordWidth-1:coordWidth]};

	assign absX = magnitude(diffX);
	assign absY = magnitude(diffY);

	always_ff @(posedge clock) begin
		if (accept) begin
			// Attribute field carries distance minus one
			distX      <= absX - 1'b1;
			distY      <= absY - 1'b1;
			dirX       <= diffX[coordWidth] ? routeGenPkg::west : routeGenPkg::east;
			dirY       <= diffY[coordWidth] ? routeGenPkg::north : routeGenPkg::south;
			zeroY      <= (absY == '0);
			cfgAttrib  <= attribWord;
			cfgRConfig <= rConfig;
			cfgLength  <= length;
			cfgStride  <= stride;
			cfgBase    <= base;
		end
	end

	//////////////////////////////////////////////////////////////
	// Word composition
	//////////////////////////////////////////////////////////////
	always_comb begin
		attribData = '0;
		attribData[dataWidth-1 -: 4] = routeGenPkg::attribMarker;
		attribData[8 +: coordWidth] = (state == routeGenPkg::sendAttribY) ? distY : distX;
	end

	always_comb begin
		routeData = '0;
		routeData[3:0] = (state == routeGenPkg::sendRouteY) ? dirY : dirX;
	end

	always_comb begin
		case (configCount)
			3'd0:    configData = cfgAttrib;
			3'd1:    configData = cfgRConfig;
			3'd2:    configData = cfgLength;
			3'd3:    configData = cfgStride;
			default: configData = cfgBase;
		endcase
	end

	always_comb begin
		case (state)
			routeGenPkg::sendAttribX,
			routeGenPkg::sendAttribY: writeData = attribData;
			routeGenPkg::sendConfig:  writeData = configData;
			default:                  writeData = routeData;
		endcase
	end

	assign writeEnable = (state != routeGenPkg::idle) && !full;
	assign writeLast   = (state == routeGenPkg::sendConfig) && (configCount == lastConfig);

	//////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= routeGenPkg::idle;
			configCount <= '0;
		end else begin
			case (state)
				routeGenPkg::idle: begin
					// Axes with equal coordinates are skipped
					if (accept) begin
						if (absX != '0) begin
							state <= routeGenPkg::sendAttribX;
						end else if (absY != '0) begin
							state <= routeGenPkg::sendAttribY;
						end else begin
							state <= routeGenPkg::sendConfig;
						end
					end
				end
				routeGenPkg::sendAttribX: begin
					if (writeEnable) begin
						state <= routeGenPkg::sendRouteX;
					end
				end
				routeGenPkg::sendRouteX: begin
					if (writeEnable) begin
						state <= zeroY ? routeGenPkg::sendConfig : routeGenPkg::sendAttribY;
					end
				end
				routeGenPkg::sendAttribY: begin
					if (writeEnable) begin
						state <= routeGenPkg::sendRouteY;
					end
				end
				routeGenPkg::sendRouteY: begin
					if (writeEnable) begin
						state <= routeGenPkg::sendConfig;
					end
				end
				routeGenPkg::sendConfig: begin
					if (writeEnable && writeLast) begin
						state       <= routeGenPkg::idle;
						configCount <= '0;
					end else if (writeEnable) begin
						configCount <= configCount + 1'b1;
					end
				end
				default: begin
					state <= routeGenPkg::idle;
				end
			endcase
		end
	end

	// Busy until the sender reports the base word accepted
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (done) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end
	end

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Build and run the routeGen testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module routeGenTb -f routeGen.f -o simRouteGen
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simRouteGen > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TEST OK" sim.log; then
	exit 0
fi
exit 1

// ==== wordFifo.sv ====
// Circular word buffer with a last-word tag per entry
`timescale 1ns/1ps

module wordFifo #(
	parameter int dataWidth = routeGenPkg::defaultDataWidth,
	parameter int fifoDepth = 4
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 writeEnable,
	input  logic [dataWidth-1:0] writeData,
	input  logic                 writeLast,
	input  logic                 readEnable,
	output logic                 full,
	output logic                 empty,
	output logic [dataWidth-1:0] readData,
	output logic                 readLast
);

	localparam int ptrWidth   = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
	localparam int countWidth = $clog2(fifoDepth + 1);
	localparam logic [ptrWidth-1:0]   lastIndex = ptrWidth'(fifoDepth - 1);
	localparam logic [countWidth-1:0] maxCount  = countWidth'(fifoDepth);

	// Tag sits above the data bits
	logic [dataWidth:0] memory [fifoDepth];

	logic [ptrWidth-1:0]   writePtr;
	logic [ptrWidth-1:0]   readPtr;
	logic [countWidth-1:0] count;

	logic doWrite;
	logic doRead;

	assign doWrite = writeEnable && !full;
	assign doRead  = readEnable && !empty;

	assign full  = (count == maxCount);
	assign empty = (count == '0);

	assign readData = memory[readPtr][dataWidth-1:0];
	assign readLast = memory[readPtr][dataWidth];

	always_ff @(posedge clock) begin
		if (doWrite) begin
			memory[writePtr] <= {writeLast, writeData};
		end
	end

	//////////////////////////////////////////////////////////////
	// Pointers and occupancy
	//////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr <= '0;
			readPtr  <= '0;
			count    <= '0;
		end else begin
			if (doWrite) begin
				writePtr <= (writePtr == lastIndex) ? '0 : writePtr + 1'b1;
			end
			if (doRead) begin
				readPtr <= (readPtr == lastIndex) ? '0 : readPtr + 1'b1;
			end
			// Simultaneous read and write leaves the count alone
			if (doWrite && !doRead) begin
				count <= count + 1'b1;
			end else if (doRead && !doWrite) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== wordSender.sv ====
// Output stage: drains the buffer onto the data port under stall
// and pulses done when the last-tagged word is accepted
`timescale 1ns/1ps

module wordSender #(
	parameter int dataWidth = routeGenPkg::defaultDataWidth
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 stall,
	input  logic [dataWidth-1:0] readData,
	input  logic                 readLast,
	input  logic                 empty,
	output logic                 readEnable,
	output logic [dataWidth-1:0] data,
	output logic                 dataValid,
	output logic                 done
);

	logic lastTag;
	logic load;

	// Register free, or its word leaves this cycle
	assign load       = !dataValid || !stall;
	assign readEnable = load && !empty;

	assign done = dataValid && !stall && lastTag;

	always_ff @(posedge clock) begin
		if (reset) begin
			dataValid <= 1'b0;
		end else if (load) begin
			dataValid <= !empty;
		end
	end

	// Held steady while stalled
	always_ff @(posedge clock) begin
		if (readEnable) begin
			data    <= readData;
			lastTag <= readLast;
		end
	end

endmodule
